// ==== Makefile ====
# Verilator lint and simulation of the scanline display

VERILATOR  = verilator
TOP        = display_tb
FILELIST   = build.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
RUN_FLAGS  = +verilator+error+limit+1000
OBJ_DIR    = obj_dir
PASS_TEXT  = Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
logic/raster_pkg.sv
logic/serial_rx.sv
logic/span_fill.sv
logic/line_buffer.sv
logic/display_spi.sv
logic/display_top.sv
dv/tb_clock.sv
dv/display_monitor.sv
dv/display_checker.sv
dv/display_tb.sv

// ==== dv/display_checker.sv ====
// Display checker
// Assertions on panel pins, host flow control and the bypass mux
`default_nettype none

module display_checker
(
    input wire clk,
    input wire rst_n,
    input wire bypass,
    input wire spi_cs_n,
    input wire serial_mosi,
    input wire serial_sck,
    input wire serial_cts,
    input wire serial_tft_mux,
    input wire tft_cs,
    input wire tft_dc,
    input wire display_mosi,
    input wire display_sck,
    input wire display_cs,
    input wire display_dc
);
    int fail_count = 0;

    // No host words while a line is on the wire
    cts_low_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        (!bypass && !display_cs) |-> !serial_cts)
    else
    begin
        fail_count++;
        $error("serial_cts high while a panel frame is active");
    end

    // Streamer idle means a quiet bus
    quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (!bypass && spi_cs_n) |-> (display_dc && !display_sck))
    else
    begin
        fail_count++;
        $error("display_dc low or display_sck high while the streamer is idle");
    end

    // Select is registered, so the pins follow one cycle after serial_tft_mux
    bypass_follow: assert property (@(posedge clk) disable iff (!rst_n)
        $past(serial_tft_mux) |-> (display_mosi == serial_mosi &&
                                   display_sck == serial_sck &&
                                   display_cs == tft_cs && display_dc == tft_dc))
    else
    begin
        fail_count++;
        $error("panel pins do not follow the host pins during bypass");
    end

endmodule

`default_nettype wire

// ==== dv/display_monitor.sv ====
// Panel monitor
// Rebuilds pixels from the panel pins and compares each frame with the expected line
`default_nettype none

module display_monitor
(
    input  wire                                                   clk,
    input  wire                                                   frame_req,
    input  wire                                                   check_idle,
    input  wire                                                   bypass,
    input  wire raster_pkg::pixel_t [raster_pkg::line_pixels-1:0] exp_line,
    input  wire                                                   display_mosi,
    input  wire                                                   display_sck,
    input  wire                                                   display_cs,
    input  wire                                                   display_dc,
    input  wire                                                   display_reset,
    input  wire                                                   serial_cts,
    output int                                                    errors,
    output int                                                    frames
);
    import raster_pkg::*;

    localparam int start_limit = 20000;
    localparam int frame_limit = 10000;

    pixel_t [line_pixels-1:0] exp_q;

    task automatic check_idle_pins();
        if (display_cs !== 1'b1 || display_sck !== 1'b0 || serial_cts !== 1'b1 ||
            display_dc !== 1'b1 || display_reset !== 1'b1)
        begin
            $display("Fail %0t: idle pins cs=%b sck=%b cts=%b dc=%b reset=%b", $time,
                     display_cs, display_sck, serial_cts, display_dc, display_reset);
            errors++;
        end
    endtask

    task automatic capture_frame();
        int     wait_cnt;
        int     bits;
        int     idx;
        logic   sck_prev;
        pixel_t shift;
        wait_cnt = 0;
        bits = 0;
        shift = '0;
        // Frame may sit behind a bypass period
        while (display_cs !== 1'b0 || bypass)
        begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > start_limit)
            begin
                $display("Timeout waiting for panel frame %0d to start", frames);
                errors++;
                return;
            end
        end
        sck_prev = display_sck;
        wait_cnt = 0;
        while (display_cs === 1'b0)
        begin
            if (display_sck && !sck_prev && !bypass)
            begin
                shift = {shift[pixel_bits-2:0], display_mosi};
                bits++;
                if (bits % pixel_bits == 0 && bits / pixel_bits <= line_pixels)
                begin
                    idx = bits / pixel_bits - 1;
                    if (shift !== exp_q[idx])
                    begin
                        $display("Fail %0t: pixel %0d is %h, expected %h", $time,
                                 idx, shift, exp_q[idx]);
                        errors++;
                    end
                end
            end
            sck_prev = display_sck;
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > frame_limit)
            begin
                $display("Timeout: panel frame %0d never ended", frames);
                errors++;
                return;
            end
        end
        if (bits != line_pixels * pixel_bits)
        begin
            $display("Panel frame %0d had %0d bits instead of %0d", frames, bits,
                     line_pixels * pixel_bits);
            errors++;
        end
    endtask

    initial
    begin
        errors = 0;
        frames = 0;
        forever
        begin
            @(posedge clk);
            if (check_idle)
                check_idle_pins();
            if (frame_req)
            begin
                exp_q = exp_line;
                capture_frame();
                frames++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/display_tb.sv ====
// Scanline display testbench
// Random host commands over the serial link, line model and panel frame checks
`default_nettype none

module display_tb;
    import raster_pkg::*;

    localparam int cts_limit  = 20000;
    localparam int done_limit = 30000;
    localparam int rounds     = 6;

    logic clk;
    logic rst_n;
    logic serial_mosi;
    logic serial_sck;
    logic serial_cs;
    logic serial_tft_mux;
    logic tft_cs;
    logic tft_dc;
    logic serial_cts;
    logic display_mosi;
    logic display_sck;
    logic display_cs;
    logic display_dc;
    logic display_reset;
    logic frame_req;
    logic check_idle;

    pixel_t [line_pixels-1:0] exp_line;
    pixel_t                   model [line_pixels];
    logic [31:0]              rng;
    int                       mon_errors;
    int                       frames;
    int                       flushes;
    int                       tb_timeouts;
    int                       r_idx;

    tb_clock u_clock (.clk(clk));

    display_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .serial_mosi    (serial_mosi),
        .serial_sck     (serial_sck),
        .serial_cs      (serial_cs),
        .serial_cts     (serial_cts),
        .serial_tft_mux (serial_tft_mux),
        .display_mosi   (display_mosi),
        .display_sck    (display_sck),
        .display_cs     (display_cs),
        .display_dc     (display_dc),
        .display_reset  (display_reset),
        .tft_cs         (tft_cs),
        .tft_dc         (tft_dc)
    );

    display_monitor u_monitor (
        .clk           (clk),
        .frame_req     (frame_req),
        .check_idle    (check_idle),
        .bypass        (serial_tft_mux),
        .exp_line      (exp_line),
        .display_mosi  (display_mosi),
        .display_sck   (display_sck),
        .display_cs    (display_cs),
        .display_dc    (display_dc),
        .display_reset (display_reset),
        .serial_cts    (serial_cts),
        .errors        (mon_errors),
        .frames        (frames)
    );

    bind display_top display_checker u_checker (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic cmd_word_t make_word(input logic [3:0] op, input xpos_t x,
                                            input xpos_t run_m1, input pixel_t color);
        return {op, x, run_m1, color};
    endfunction

    task automatic finish_run();
        int total;
        total = mon_errors + uut.u_checker.fail_count + tb_timeouts;
        $display("Errors: %0d monitor, %0d assertion, %0d timeout", mon_errors,
                 uut.u_checker.fail_count, tb_timeouts);
        if (total == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    task automatic wait_cts();
        int cnt;
        cnt = 0;
        while (serial_cts !== 1'b1)
        begin
            @(posedge clk);
            cnt++;
            if (cnt > cts_limit)
            begin
                $display("Timeout waiting for serial_cts to rise");
                tb_timeouts++;
                finish_run();
            end
        end
    endtask

    // Host SPI master, sck half period of 6 clk cycles
    task automatic send_word(input cmd_word_t w);
        int i;
        wait_cts();
        @(posedge clk);
        serial_cs <= 1'b0;
        for (i = 31; i >= 0; i--)
        begin
            serial_mosi <= w[i];
            serial_sck  <= 1'b0;
            repeat (6) @(posedge clk);
            serial_sck <= 1'b1;
            repeat (6) @(posedge clk);
        end
        serial_sck <= 1'b0;
        serial_cs  <= 1'b1;
        repeat (6) @(posedge clk);
    endtask

    task automatic apply_fill(input xpos_t x, input xpos_t run_m1, input pixel_t color);
        int i;
        // Span clipped at the right edge, no wrap
        for (i = 0; i <= int'(run_m1); i++)
            if (int'(x) + i < line_pixels)
                model[int'(x) + i] = color;
        send_word(make_word(op_fill, x, run_m1, color));
    endtask

    task automatic send_flush();
        int i;
        @(posedge clk);
        for (i = 0; i < line_pixels; i++)
            exp_line[i] <= model[i];
        frame_req <= 1'b1;
        @(posedge clk);
        frame_req <= 1'b0;
        flushes++;
        rng = xorshift32(rng);
        send_word(make_word(op_flush, rng[27:22], rng[21:16], rng[15:0]));
    endtask

    task automatic random_command();
        logic [31:0] r;
        logic [3:0]  op;
        rng = xorshift32(rng);
        r = rng;
        op = 4'd3 + r[28:25] % 4'd13;
        case (r[31:29])
            3'd0: send_word(make_word(op_nop, r[27:22], r[21:16], r[15:0]));
            3'd1: send_word(make_word(op, r[27:22], r[21:16], r[15:0]));
            // Near the right edge, mostly clipped
            3'd2: apply_fill(6'd48 + 6'(r[25:22]), r[21:16], r[15:0]);
            default: apply_fill(r[27:22], r[21:16], r[15:0]);
        endcase
    endtask

    // Host owns the panel pins, flush queued until release
    task automatic bypass_flush();
        int i;
        int hold;
        @(posedge clk);
        serial_tft_mux <= 1'b1;
        repeat (2) @(posedge clk);
        for (i = 0; i < 16; i++)
        begin
            rng = xorshift32(rng);
            serial_mosi <= rng[0];
            serial_sck  <= rng[1];
            tft_cs      <= rng[2];
            tft_dc      <= rng[3];
            @(posedge clk);
        end
        serial_sck <= 1'b0;
        tft_cs     <= 1'b1;
        tft_dc     <= 1'b1;
        send_flush();
        rng = xorshift32(rng);
        hold = 20 + int'(rng[7:0]);
        repeat (hold) @(posedge clk);
        serial_tft_mux <= 1'b0;
    endtask

    task automatic wait_frames();
        int cnt;
        cnt = 0;
        while (frames < flushes)
        begin
            @(posedge clk);
            cnt++;
            if (cnt > done_limit)
            begin
                $display("Timeout waiting for the last panel frame");
                tb_timeouts++;
                finish_run();
            end
        end
    endtask

    initial
    begin
        rng            = 32'd95;
        rst_n          = 1'b0;
        serial_mosi    = 1'b0;
        serial_sck     = 1'b0;
        serial_cs      = 1'b1;
        serial_tft_mux = 1'b0;
        tft_cs         = 1'b1;
        tft_dc         = 1'b1;
        frame_req      = 1'b0;
        check_idle     = 1'b0;
        exp_line       = '0;
        flushes        = 0;
        tb_timeouts    = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        check_idle <= 1'b1;
        @(posedge clk);
        check_idle <= 1'b0;

        // Whole line in one color
        rng = xorshift32(rng);
        apply_fill(6'd0, 6'd63, rng[15:0]);
        send_flush();

        for (r_idx = 0; r_idx < rounds; r_idx++)
        begin
            rng = xorshift32(rng);
            repeat (3 + int'(rng[1:0])) random_command();
            if (r_idx == 2 || r_idx == rounds - 1)
                bypass_flush();
            else
                send_flush();
        end
        wait_frames();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
// Testbench clock
// Free-running clock, period 8
`default_nettype none

module tb_clock
(
    output logic clk
);
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end
endmodule

`default_nettype wire

// ==== logic/display_spi.sv ====
// Display streamer
// Reads the line buffer and shifts the pixels out to the SPI panel, MSB first
`default_nettype none

module display_spi
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    start,
    output raster_pkg::xpos_t      rd_addr,
    input  wire raster_pkg::pixel_t rd_data,
    output logic                   mosi,
    output logic                   sck,
    output logic                   cs_n,
    output logic                   done
);
    import raster_pkg::*;

    stream_state_e state;
    xpos_t         pix_idx;
    pixel_t        shreg;

    logic [$clog2(pixel_bits)-1:0]      bit_cnt;
    logic [$clog2(spi_half_period)-1:0] half_cnt;

    logic half_end;
    logic fall;
    logic pixel_end;
    logic last_pixel;

    assign half_end   = (half_cnt == spi_half_period - 1);
    assign fall       = (state == stream_shift) && half_end && sck;
    assign pixel_end  = fall && (bit_cnt == pixel_bits - 1);
    // pix_idx points one ahead, so it has wrapped to 0 during pixel 63
    assign last_pixel = (pix_idx == '0);

    // Idle leaves the address at 0, so pixel 0 is already on rd_data in load
    assign rd_addr = pix_idx;
    assign mosi    = shreg[pixel_bits-1];

    ////////////////////////////////////////////////////////////////////////////
    // Stream FSM and sck divider
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= stream_idle;
            pix_idx  <= '0;
            bit_cnt  <= '0;
            half_cnt <= '0;
            sck      <= 1'b0;
            cs_n     <= 1'b1;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                stream_idle:
                begin
                    // Close the frame one cycle after the last falling edge
                    if (!cs_n)
                    begin
                        cs_n <= 1'b1;
                        done <= 1'b1;
                    end
                    else if (start)
                        state <= stream_load;
                end
                stream_load:
                begin
                    cs_n     <= 1'b0;
                    pix_idx  <= pix_idx + 1'b1;
                    bit_cnt  <= '0;
                    half_cnt <= '0;
                    sck      <= 1'b0;
                    state    <= stream_shift;
                end
                stream_shift:
                begin
                    half_cnt <= half_end ? '0 : half_cnt + 1'b1;
                    if (half_end)
                        sck <= ~sck;
                    if (fall)
                        bit_cnt <= bit_cnt + 1'b1;
                    if (pixel_end)
                    begin
                        if (last_pixel)
                            state <= stream_idle;
                        else
                            pix_idx <= pix_idx + 1'b1;
                    end
                end
                default: state <= stream_idle;
            endcase
        end
    end

    // Data changes on the falling phase, next pixel prefetched during last bit
    always_ff @(posedge clk)
    begin
        if (state == stream_load || (pixel_end && !last_pixel))
            shreg <= rd_data;
        else if (fall)
            shreg <= {shreg[pixel_bits-2:0], 1'b0};
    end

endmodule

`default_nettype wire

// ==== logic/display_top.sv ====
// Scanline display top
// Host serial receiver, span fill engine, line buffer and panel streamer with bypass
`default_nettype none

module display_top
(
    input  wire  clk,
    input  wire  rst_n,

    // Host serial link
    input  wire  serial_mosi,
    input  wire  serial_sck,
    input  wire  serial_cs,
    output logic serial_cts,
    input  wire  serial_tft_mux,

    // Panel
    output logic display_mosi,
    output logic display_sck,
    output logic display_cs,
    output logic display_dc,
    output logic display_reset,
    input  wire  tft_cs,
    input  wire  tft_dc
);
    import raster_pkg::*;

    logic      core_rst_n;
    logic      bypass;
    cmd_word_t word;
    logic      word_valid;
    pixel_wr_t wr;
    logic      start;
    logic      done;
    logic      busy;
    xpos_t     rd_addr;
    pixel_t    rd_data;
    logic      spi_mosi;
    logic      spi_sck;
    logic      spi_cs_n;

    ////////////////////////////////////////////////////////////////////////////
    // Reset and bypass registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            core_rst_n <= 1'b0;
        else
            core_rst_n <= 1'b1;
    end

    always_ff @(posedge clk or negedge core_rst_n)
    begin
        if (!core_rst_n)
            bypass <= 1'b0;
        else
            bypass <= serial_tft_mux;
    end

    // Host drives the panel directly while bypassed
    assign display_mosi  = bypass ? serial_mosi : spi_mosi;
    assign display_sck   = bypass ? serial_sck  : spi_sck;
    assign display_cs    = bypass ? tft_cs      : spi_cs_n;
    assign display_dc    = bypass ? tft_dc      : 1'b1;
    assign display_reset = core_rst_n;
    assign serial_cts    = ~busy;

    ////////////////////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////////////////////
    serial_rx u_serial_rx (
        .clk        (clk),
        .rst_n      (core_rst_n),
        .sck        (serial_sck),
        .cs         (serial_cs),
        .mosi       (serial_mosi),
        .word       (word),
        .word_valid (word_valid)
    );

    span_fill u_span_fill (
        .clk        (clk),
        .rst_n      (core_rst_n),
        .word       (word),
        .word_valid (word_valid),
        .bypass     (bypass),
        .done       (done),
        .wr         (wr),
        .start      (start),
        .busy       (busy)
    );

    line_buffer u_line_buffer (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    display_spi u_display_spi (
        .clk     (clk),
        .rst_n   (core_rst_n),
        .start   (start),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .mosi    (spi_mosi),
        .sck     (spi_sck),
        .cs_n    (spi_cs_n),
        .done    (done)
    );

endmodule

`default_nettype wire

// ==== logic/line_buffer.sv ====
// Line buffer
// One scanline of RGB565 pixels, single write port and registered read port
`default_nettype none

module line_buffer
(
    input  wire                        clk,
    input  wire raster_pkg::pixel_wr_t wr,
    input  wire raster_pkg::xpos_t     rd_addr,
    output raster_pkg::pixel_t         rd_data
);
    import raster_pkg::*;

    pixel_t mem [line_pixels];

    always_ff @(posedge clk)
    begin
        if (wr.en)
            mem[wr.addr] <= wr.data;
    end

    // Read data arrives one cycle after the address
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== logic/raster_pkg.sv ====
// Raster package
// Shared sizes, pixel and command types, and FSM states for the scanline display
`default_nettype none

package raster_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////////////////////
    localparam int line_pixels     = 64;
    localparam int pixel_bits      = 16;
    localparam int word_bits       = 32;
    // clk cycles per half period of the panel sck
    localparam int spi_half_period = 2;

    typedef logic [pixel_bits-1:0]          pixel_t;
    typedef logic [$clog2(line_pixels)-1:0] xpos_t;
    typedef logic [word_bits-1:0]           cmd_word_t;

    ////////////////////////////////////////////////////////////////////////////
    // Command word
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_fill  = 4'd1,
        op_flush = 4'd2
    } opcode_e;

    // Bit layout of a host word
    typedef struct packed {
        opcode_e opcode;
        xpos_t   x_start;
        xpos_t   run_minus_one;
        pixel_t  color;
    } fill_cmd_t;

    typedef struct packed {
        logic   en;
        xpos_t  addr;
        pixel_t data;
    } pixel_wr_t;

    ////////////////////////////////////////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        fill_idle,
        fill_run,
        fill_flush_wait
    } fill_state_e;

    typedef enum logic [1:0] {
        stream_idle,
        stream_load,
        stream_shift
    } stream_state_e;

endpackage

`default_nettype wire

// ==== logic/serial_rx.sv ====
// Serial word receiver
// SPI slave: synchronizes sck, cs and mosi and builds 32-bit command words
`default_nettype none

module serial_rx
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   sck,
    input  wire                   cs,
    input  wire                   mosi,
    output raster_pkg::cmd_word_t word,
    output logic                  word_valid
);
    import raster_pkg::*;

    logic [1:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sck_prev;
    logic       cs_prev;
    logic       sck_rise;
    logic       cs_rise;

    logic [$clog2(word_bits)-1:0] bit_cnt;
    cmd_word_t                    shift_q;

    ////////////////////////////////////////////////////////////////////////////
    // Synchronizers and edge detect
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_sync  <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
            sck_prev  <= 1'b0;
            cs_prev   <= 1'b1;
        end
        else
        begin
            sck_sync  <= {sck_sync[0], sck};
            cs_sync   <= {cs_sync[0], cs};
            mosi_sync <= {mosi_sync[0], mosi};
            sck_prev  <= sck_sync[1];
            cs_prev   <= cs_sync[1];
        end
    end

    // Only clock edges inside an active frame count
    assign sck_rise = sck_sync[1] & ~sck_prev & ~cs_sync[1];
    assign cs_rise  = cs_sync[1] & ~cs_prev;

    ////////////////////////////////////////////////////////////////////////////
    // Bit counter and word strobe
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end
        else
        begin
            word_valid <= 1'b0;
            if (cs_rise)
                // Drop a partial word
                bit_cnt <= '0;
            else if (sck_rise)
            begin
                bit_cnt    <= bit_cnt + 1'b1;
                word_valid <= (bit_cnt == word_bits - 1);
            end
        end
    end

    // MSB first
    always_ff @(posedge clk)
    begin
        if (sck_rise)
            shift_q <= {shift_q[word_bits-2:0], mosi_sync[1]};
    end

    assign word = shift_q;

endmodule

`default_nettype wire

// ==== logic/span_fill.sv ====
// Span fill engine
// Decodes host words, paints pixel runs into the line buffer and starts flushes
`default_nettype none

module span_fill
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire raster_pkg::cmd_word_t word,
    input  wire                   word_valid,
    input  wire                   bypass,
    input  wire                   done,
    output raster_pkg::pixel_wr_t wr,
    output logic                  start,
    output logic                  busy
);
    import raster_pkg::*;

    fill_state_e state;
    fill_cmd_t   cmd;
    xpos_t       addr_q;
    xpos_t       remain_q;
    pixel_t      color_q;
    logic        started;
    logic        run_end;

    assign cmd = fill_cmd_t'(word);

    // Stop after the run or at the right edge, whichever comes first
    assign run_end = (remain_q == '0) || (addr_q == xpos_t'(line_pixels - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Fill FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= fill_idle;
            start   <= 1'b0;
            started <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            case (state)
                fill_idle:
                begin
                    if (word_valid)
                    begin
                        case (cmd.opcode)
                            op_fill:  state <= fill_run;
                            op_flush:
                            begin
                                state   <= fill_flush_wait;
                                started <= 1'b0;
                            end
                            op_nop:   state <= fill_idle;
                            default:  state <= fill_idle;
                        endcase
                    end
                end
                fill_run:
                begin
                    if (run_end)
                        state <= fill_idle;
                end
                fill_flush_wait:
                begin
                    // Panel pins belong to the host while bypassed
                    if (!started)
                    begin
                        if (!bypass)
                        begin
                            start   <= 1'b1;
                            started <= 1'b1;
                        end
                    end
                    else if (done)
                        state <= fill_idle;
                end
                default: state <= fill_idle;
            endcase
        end
    end

    // Span registers, loaded when a fill is accepted
    always_ff @(posedge clk)
    begin
        if (state == fill_idle && word_valid)
        begin
            addr_q   <= cmd.x_start;
            remain_q <= cmd.run_minus_one;
            color_q  <= cmd.color;
        end
        else if (state == fill_run)
        begin
            addr_q   <= addr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
        end
    end

    assign wr.en   = (state == fill_run);
    assign wr.addr = addr_q;
    assign wr.data = color_q;

    assign busy = (state != fill_idle);

endmodule

`default_nettype wire
